// File: common/au_pkg.sv
/* Shared widths, opcode field positions, function codes and flag positions
   for the arithmetic unit, referenced by scoped name */
`default_nettype none

package au_pkg;

    localparam int data_width    = 32;
    localparam int reg_count     = 8;
    localparam int reg_idx_width = 3;
    localparam int op_width      = 15;

    // Opcode fields
    localparam int src_a_lsb     = 0;
    localparam int src_b_lsb     = 3;
    localparam int dst3_lsb      = 6;
    localparam int func3_lsb     = 9;
    localparam int func3_width   = 4;
    localparam int func_un_lsb   = 6;
    localparam int func_un_width = 5;
    localparam int func_sh_lsb   = 8;
    localparam int func_sh_width = 3;
    localparam int shamt_lsb     = 3;
    localparam int shamt_width   = 5;

    // Group codes, matched against the top opcode bits
    localparam logic [1:0] grp_alu3  = 2'b00;
    localparam logic [3:0] grp_unary = 4'b0100;
    localparam logic [3:0] grp_shift = 4'b0101;

    localparam logic [3:0] f_or  = 4'd0;
    localparam logic [3:0] f_and = 4'd1;
    localparam logic [3:0] f_xor = 4'd2;
    localparam logic [3:0] f_add = 4'd3;
    localparam logic [3:0] f_sub = 4'd4;

    localparam logic [4:0] u_not    = 5'h00;
    localparam logic [4:0] u_neg    = 5'h01;
    localparam logic [4:0] u_sext8  = 5'h02;
    localparam logic [4:0] u_sext16 = 5'h03;
    localparam logic [4:0] u_test   = 5'h1E;
    localparam logic [4:0] u_cmp    = 5'h1F;

    localparam logic [2:0] s_bclr = 3'd0;
    localparam logic [2:0] s_bset = 3'd1;
    localparam logic [2:0] s_shl  = 3'd4;
    localparam logic [2:0] s_shr  = 3'd5;
    localparam logic [2:0] s_asr  = 3'd6;

    localparam int flag_width = 4;
    localparam int flag_z     = 0;
    localparam int flag_n     = 1;
    localparam int flag_c     = 2;
    localparam int flag_v     = 3;

    typedef enum logic [4:0] {
        k_imm, k_or, k_and, k_xor, k_add, k_sub,
        k_not, k_neg, k_sext8, k_sext16, k_test, k_cmp,
        k_bclr, k_bset, k_shl, k_shr, k_asr, k_zero
    } op_kind_t;

endpackage

`default_nettype wire

// File: common/au_operand_if.sv
/* Captured operands and decoded control, passed from operand fetch
   to execute */
`timescale 1ns/100ps
`default_nettype none

interface au_operand_if;

    logic                                  valid;
    logic                                  store_en;
    logic                                  flag_en;
    au_pkg::op_kind_t                      kind;
    logic [au_pkg::reg_idx_width-1:0]      dst;
    // Sign-extended to one bit above the register width
    logic [au_pkg::data_width:0]           a;
    logic [au_pkg::data_width:0]           b;
    logic [au_pkg::shamt_width-1:0]        shamt;

    modport fetch (
        output valid, store_en, flag_en, kind, dst, a, b, shamt
    );

    modport exec (
        input valid, store_en, flag_en, kind, dst, a, b, shamt
    );

endinterface

`default_nettype wire

// File: common/au_result_if.sv
/* Raw result with carry and overflow, passed from execute to writeback */
`timescale 1ns/100ps
`default_nettype none

interface au_result_if;

    logic                              valid;
    logic                              store_en;
    logic                              flag_en;
    logic [au_pkg::reg_idx_width-1:0]  dst;
    logic [au_pkg::data_width:0]       result;
    logic                              carry;
    logic                              overflow;

    modport exec (
        output valid, store_en, flag_en, dst, result, carry, overflow
    );

    modport wb (
        input valid, store_en, flag_en, dst, result, carry, overflow
    );

endinterface

`default_nettype wire

// File: hdl/au_reg_file.sv
/* Eight-entry register file with two combinational read ports for
   operand fetch and one clocked write port from writeback */
`timescale 1ns/100ps
`default_nettype none

module au_reg_file
(
    input  wire logic                                 clk,
    input  wire logic                                 rst,

    input  wire logic [au_pkg::reg_idx_width-1:0]     rd_a_idx,
    input  wire logic [au_pkg::reg_idx_width-1:0]     rd_b_idx,
    output logic      [au_pkg::data_width-1:0]        rd_a,
    output logic      [au_pkg::data_width-1:0]        rd_b,

    input  wire logic                                 wr_en,
    input  wire logic [au_pkg::reg_idx_width-1:0]     wr_idx,
    input  wire logic [au_pkg::data_width-1:0]        wr_data
);

    logic [au_pkg::data_width-1:0] regs [au_pkg::reg_count];

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < au_pkg::reg_count; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr_en)
        begin
            regs[wr_idx] <= wr_data;
        end
    end

    // No bypass, a same-cycle read returns the old contents
    assign rd_a = regs[rd_a_idx];
    assign rd_b = regs[rd_b_idx];

endmodule

`default_nettype wire

// File: au/au_operand_fetch.sv
/* Stage 1 of the arithmetic unit. Reads the source registers, captures
   operands or an immediate and decodes the opcode into an operation kind */
`timescale 1ns/100ps
`default_nettype none

module au_operand_fetch
(
    input  wire logic                                 clk,
    input  wire logic                                 rst,

    input  wire logic                                 op_en,
    input  wire logic [au_pkg::op_width-1:0]          op,
    input  wire logic                                 imm_en,
    input  wire logic [au_pkg::reg_idx_width-1:0]     imm_reg,
    input  wire logic [au_pkg::data_width-1:0]        imm,

    output logic      [au_pkg::reg_idx_width-1:0]     rd_a_idx,
    output logic      [au_pkg::reg_idx_width-1:0]     rd_b_idx,
    input  wire logic [au_pkg::data_width-1:0]        rd_a,
    input  wire logic [au_pkg::data_width-1:0]        rd_b,

    au_operand_if.fetch                               opnd
);

    au_pkg::op_kind_t                  dec_kind;
    logic [au_pkg::reg_idx_width-1:0]  dec_dst;
    logic                              dec_known;

    assign rd_a_idx = op[au_pkg::src_a_lsb +: au_pkg::reg_idx_width];
    assign rd_b_idx = op[au_pkg::src_b_lsb +: au_pkg::reg_idx_width];

    always_comb
    begin
        dec_kind  = au_pkg::k_zero;
        dec_dst   = rd_a_idx;
        dec_known = 1'b1;
        if (op[au_pkg::op_width-1 -: $bits(au_pkg::grp_alu3)] == au_pkg::grp_alu3)
        begin
            dec_dst = op[au_pkg::dst3_lsb +: au_pkg::reg_idx_width];
            case (op[au_pkg::func3_lsb +: au_pkg::func3_width])
                au_pkg::f_or:  dec_kind = au_pkg::k_or;
                au_pkg::f_and: dec_kind = au_pkg::k_and;
                au_pkg::f_xor: dec_kind = au_pkg::k_xor;
                au_pkg::f_add: dec_kind = au_pkg::k_add;
                au_pkg::f_sub: dec_kind = au_pkg::k_sub;
                default:       dec_kind = au_pkg::k_zero;
            endcase
        end
        else if (op[au_pkg::op_width-1 -: $bits(au_pkg::grp_unary)] == au_pkg::grp_unary)
        begin
            case (op[au_pkg::func_un_lsb +: au_pkg::func_un_width])
                au_pkg::u_not:    dec_kind = au_pkg::k_not;
                au_pkg::u_neg:    dec_kind = au_pkg::k_neg;
                au_pkg::u_sext8:  dec_kind = au_pkg::k_sext8;
                au_pkg::u_sext16: dec_kind = au_pkg::k_sext16;
                au_pkg::u_test:   dec_kind = au_pkg::k_test;
                au_pkg::u_cmp:    dec_kind = au_pkg::k_cmp;
                default:          dec_kind = au_pkg::k_zero;
            endcase
        end
        else if (op[au_pkg::op_width-1 -: $bits(au_pkg::grp_shift)] == au_pkg::grp_shift)
        begin
            case (op[au_pkg::func_sh_lsb +: au_pkg::func_sh_width])
                au_pkg::s_bclr: dec_kind = au_pkg::k_bclr;
                au_pkg::s_bset: dec_kind = au_pkg::k_bset;
                au_pkg::s_shl:  dec_kind = au_pkg::k_shl;
                au_pkg::s_shr:  dec_kind = au_pkg::k_shr;
                au_pkg::s_asr:  dec_kind = au_pkg::k_asr;
                default:        dec_kind = au_pkg::k_zero;
            endcase
        end
        else
        begin
            dec_known = 1'b0;
        end
    end

    // Immediate has priority over an opcode in the same cycle
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            opnd.valid    <= 1'b0;
            opnd.store_en <= 1'b0;
            opnd.flag_en  <= 1'b0;
        end
        else
        begin
            opnd.valid    <= imm_en || (op_en && dec_known);
            opnd.store_en <= imm_en || (op_en && dec_known && dec_kind != au_pkg::k_test
                                        && dec_kind != au_pkg::k_cmp);
            opnd.flag_en  <= !imm_en && op_en && dec_known;
        end
    end

    always_ff @(posedge clk)
    begin
        if (imm_en)
        begin
            opnd.kind  <= au_pkg::k_imm;
            opnd.dst   <= imm_reg;
            opnd.a     <= {imm[au_pkg::data_width-1], imm};
            opnd.b     <= '0;
            opnd.shamt <= '0;
        end
        else if (op_en)
        begin
            opnd.kind  <= dec_kind;
            opnd.dst   <= dec_dst;
            opnd.a     <= {rd_a[au_pkg::data_width-1], rd_a};
            opnd.b     <= {rd_b[au_pkg::data_width-1], rd_b};
            opnd.shamt <= op[au_pkg::shamt_lsb +: au_pkg::shamt_width];
        end
    end

endmodule

`default_nettype wire

// File: au/au_execute.sv
/* Stage 2 of the arithmetic unit. Computes the wide result, carry and
   signed overflow for the decoded operation kind */
`timescale 1ns/100ps
`default_nettype none

module au_execute
(
    input  wire logic  clk,
    input  wire logic  rst,

    au_operand_if.exec opnd,
    au_result_if.exec  res
);

    localparam int msb = au_pkg::data_width - 1;

    logic [au_pkg::data_width:0]  a_u;
    logic [au_pkg::data_width:0]  b_u;
    logic [au_pkg::data_width:0]  sum_u;
    logic [au_pkg::data_width:0]  diff_u;
    logic [au_pkg::data_width:0]  neg_u;
    logic [au_pkg::data_width:0]  bit_mask;
    logic [au_pkg::data_width:0]  result;
    logic                         carry;
    logic                         overflow;

    // Unsigned views of the low word, bit 32 becomes carry or borrow
    assign a_u      = {1'b0, opnd.a[msb:0]};
    assign b_u      = {1'b0, opnd.b[msb:0]};
    assign sum_u    = a_u + b_u;
    assign diff_u   = a_u - b_u;
    assign neg_u    = '0 - b_u;
    assign bit_mask = {{au_pkg::data_width{1'b0}}, 1'b1} << opnd.shamt;

    always_comb
    begin
        result   = '0;
        carry    = 1'b0;
        overflow = 1'b0;
        case (opnd.kind)
            au_pkg::k_imm:    result = opnd.a;
            au_pkg::k_or:     result = opnd.a | opnd.b;
            au_pkg::k_and:    result = opnd.a & opnd.b;
            au_pkg::k_xor:    result = opnd.a ^ opnd.b;
            au_pkg::k_add:
            begin
                result   = opnd.a + opnd.b;
                carry    = sum_u[au_pkg::data_width];
                overflow = (opnd.a[msb] == opnd.b[msb]) && (sum_u[msb] != opnd.a[msb]);
            end
            au_pkg::k_sub, au_pkg::k_cmp:
            begin
                result   = opnd.a - opnd.b;
                carry    = diff_u[au_pkg::data_width];
                overflow = (opnd.a[msb] != opnd.b[msb]) && (diff_u[msb] != opnd.a[msb]);
            end
            // Unary operations work on operand b
            au_pkg::k_not:    result = ~opnd.b;
            au_pkg::k_neg:
            begin
                result   = '0 - opnd.b;
                carry    = neg_u[au_pkg::data_width];
                // Only the most negative value overflows
                overflow = opnd.b[msb] && neg_u[msb];
            end
            au_pkg::k_sext8:  result = {{25{opnd.b[7]}}, opnd.b[7:0]};
            au_pkg::k_sext16: result = {{17{opnd.b[15]}}, opnd.b[15:0]};
            au_pkg::k_test:   result = opnd.a & opnd.b;
            au_pkg::k_bclr:   result = opnd.a & ~bit_mask;
            au_pkg::k_bset:   result = opnd.a | bit_mask;
            au_pkg::k_shl:    result = opnd.a << opnd.shamt;
            // Zero fill from bit 31, not from the extension bit
            au_pkg::k_shr:    result = a_u >> opnd.shamt;
            au_pkg::k_asr:    result = $signed(opnd.a) >>> opnd.shamt;
            default:          result = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            res.valid    <= 1'b0;
            res.store_en <= 1'b0;
            res.flag_en  <= 1'b0;
        end
        else
        begin
            res.valid    <= opnd.valid;
            res.store_en <= opnd.store_en;
            res.flag_en  <= opnd.flag_en;
        end
    end

    always_ff @(posedge clk)
    begin
        if (opnd.valid)
        begin
            res.dst      <= opnd.dst;
            res.result   <= result;
            res.carry    <= carry;
            res.overflow <= overflow;
        end
    end

endmodule

`default_nettype wire

// File: au/au_writeback.sv
/* Stage 3 of the arithmetic unit and its output register. Drives the
   register file write and the flag outputs */
`timescale 1ns/100ps
`default_nettype none

module au_writeback
(
    input  wire logic                              clk,
    input  wire logic                              rst,

    au_result_if.wb                                res,

    output logic                                   wb_en,
    output logic [au_pkg::reg_idx_width-1:0]       wb_reg,
    output logic [au_pkg::data_width-1:0]          wb_data,
    output logic                                   flags_en,
    output logic [au_pkg::flag_width-1:0]          flags
);

    logic                              s3_store;
    logic                              s3_flag;
    logic [au_pkg::reg_idx_width-1:0]  s3_dst;
    logic [au_pkg::data_width-1:0]     s3_data;
    logic                              s3_carry;
    logic                              s3_overflow;
    logic [au_pkg::flag_width-1:0]     s3_flags;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            s3_store <= 1'b0;
            s3_flag  <= 1'b0;
            wb_en    <= 1'b0;
            flags_en <= 1'b0;
        end
        else
        begin
            s3_store <= res.valid && res.store_en;
            s3_flag  <= res.valid && res.flag_en;
            wb_en    <= s3_store;
            flags_en <= s3_flag;
        end
    end

    always_comb
    begin
        s3_flags                = '0;
        s3_flags[au_pkg::flag_z] = (s3_data == '0);
        s3_flags[au_pkg::flag_n] = s3_data[au_pkg::data_width-1];
        s3_flags[au_pkg::flag_c] = s3_carry;
        s3_flags[au_pkg::flag_v] = s3_overflow;
    end

    always_ff @(posedge clk)
    begin
        s3_dst      <= res.dst;
        s3_data     <= res.result[au_pkg::data_width-1:0];
        s3_carry    <= res.carry;
        s3_overflow <= res.overflow;
        wb_reg      <= s3_dst;
        wb_data     <= s3_data;
        flags       <= s3_flags;
    end

endmodule

`default_nettype wire

// File: hdl/au_top.sv
/* Top level of the arithmetic unit. Connects the register file and the
   three pipeline stages to the issue, immediate and writeback ports */
`timescale 1ns/100ps
`default_nettype none

module au_top
(
    input  wire logic                                 clk,
    input  wire logic                                 rst,

    input  wire logic                                 au_op_en,
    input  wire logic [au_pkg::op_width-1:0]          au_op,

    input  wire logic                                 rf_imm_en,
    input  wire logic [au_pkg::reg_idx_width-1:0]     rf_imm_reg,
    input  wire logic [au_pkg::data_width-1:0]        rf_imm,

    output logic                                      wb_au_en,
    output logic      [au_pkg::reg_idx_width-1:0]     wb_au_reg,
    output logic      [au_pkg::data_width-1:0]        wb_au_data,
    output logic                                      wb_au_flags_en,
    output logic      [au_pkg::flag_width-1:0]        wb_au_flags
);

    logic [au_pkg::reg_idx_width-1:0]  rd_a_idx;
    logic [au_pkg::reg_idx_width-1:0]  rd_b_idx;
    logic [au_pkg::data_width-1:0]     rd_a;
    logic [au_pkg::data_width-1:0]     rd_b;

    au_operand_if opnd_if ();
    au_result_if  res_if ();

    // Writeback outputs also feed the register file write port
    au_reg_file u_reg_file
    (
        .clk      (clk),
        .rst      (rst),
        .rd_a_idx (rd_a_idx),
        .rd_b_idx (rd_b_idx),
        .rd_a     (rd_a),
        .rd_b     (rd_b),
        .wr_en    (wb_au_en),
        .wr_idx   (wb_au_reg),
        .wr_data  (wb_au_data)
    );

    au_operand_fetch u_fetch
    (
        .clk      (clk),
        .rst      (rst),
        .op_en    (au_op_en),
        .op       (au_op),
        .imm_en   (rf_imm_en),
        .imm_reg  (rf_imm_reg),
        .imm      (rf_imm),
        .rd_a_idx (rd_a_idx),
        .rd_b_idx (rd_b_idx),
        .rd_a     (rd_a),
        .rd_b     (rd_b),
        .opnd     (opnd_if.fetch)
    );

    au_execute u_execute
    (
        .clk  (clk),
        .rst  (rst),
        .opnd (opnd_if.exec),
        .res  (res_if.exec)
    );

    au_writeback u_writeback
    (
        .clk      (clk),
        .rst      (rst),
        .res      (res_if.wb),
        .wb_en    (wb_au_en),
        .wb_reg   (wb_au_reg),
        .wb_data  (wb_au_data),
        .flags_en (wb_au_flags_en),
        .flags    (wb_au_flags)
    );

endmodule

`default_nettype wire

// File: verif/au_checker.sv
/* Concurrent assertions on the arithmetic unit ports, bound to au_top.
   Checks strobe timing after reset and the writeback slot of each issue */
`timescale 1ns/100ps
`default_nettype none

module au_checker
(
    input  wire logic                            clk,
    input  wire logic                            rst,
    input  wire logic                            au_op_en,
    input  wire logic [au_pkg::op_width-1:0]     au_op,
    input  wire logic                            rf_imm_en,
    input  wire logic                            wb_au_en,
    input  wire logic                            wb_au_flags_en
);

    int         fail_count = 0;
    logic [2:0] post_rst;
    logic       op_known;
    logic       op_flag_only;
    logic       arith_issue;

    // Edges seen since reset went low, saturating
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            post_rst <= '0;
        end
        else if (post_rst != 3'd7)
        begin
            post_rst <= post_rst + 3'd1;
        end
    end

    assign op_known = (au_op[14:13] == au_pkg::grp_alu3)
                   || (au_op[14:11] == au_pkg::grp_unary)
                   || (au_op[14:11] == au_pkg::grp_shift);

    // Test and compare only raise flags
    assign op_flag_only = (au_op[14:11] == au_pkg::grp_unary)
                       && ((au_op[10:6] == au_pkg::u_test) || (au_op[10:6] == au_pkg::u_cmp));

    assign arith_issue = !rf_imm_en && au_op_en && op_known;

    a_quiet_after_reset: assert property (@(posedge clk)
        (rst || post_rst < 3'd4) |-> (!wb_au_en && !wb_au_flags_en))
    else
    begin
        fail_count++;
        $error("output strobe during reset or right after it");
    end

    // Outputs set at the third edge after issue are sampled one edge later
    a_imm_slot: assert property (@(posedge clk) disable iff (rst)
        rf_imm_en |-> ##4 (wb_au_en && !wb_au_flags_en))
    else
    begin
        fail_count++;
        $error("immediate load did not give a lone write strobe");
    end

    a_store_slot: assert property (@(posedge clk) disable iff (rst)
        (arith_issue && !op_flag_only) |-> ##4 (wb_au_en && wb_au_flags_en))
    else
    begin
        fail_count++;
        $error("arithmetic issue did not give write and flag strobes");
    end

    a_flag_slot: assert property (@(posedge clk) disable iff (rst)
        (arith_issue && op_flag_only) |-> ##4 (!wb_au_en && wb_au_flags_en))
    else
    begin
        fail_count++;
        $error("test or compare did not give a lone flag strobe");
    end

    a_idle_slot: assert property (@(posedge clk) disable iff (rst)
        (!rf_imm_en && !arith_issue) |-> ##4 (!wb_au_en && !wb_au_flags_en))
    else
    begin
        fail_count++;
        $error("strobe without a recognized issue");
    end

    a_flags_source: assert property (@(posedge clk) disable iff (rst)
        wb_au_flags_en |-> $past(arith_issue, 4))
    else
    begin
        fail_count++;
        $error("flag strobe without an arithmetic issue before it");
    end

endmodule

`default_nettype wire

// File: verif/au_tb.sv
/* Testbench for au_top. Random issue and immediate stimulus, checked
   against a pipelined reference model of the register file */
`timescale 1ns/100ps
`default_nettype none

module au_tb;

    logic                                  clk;
    logic                                  rst;
    logic                                  au_op_en;
    logic [au_pkg::op_width-1:0]           au_op;
    logic                                  rf_imm_en;
    logic [au_pkg::reg_idx_width-1:0]      rf_imm_reg;
    logic [au_pkg::data_width-1:0]         rf_imm;
    logic                                  wb_au_en;
    logic [au_pkg::reg_idx_width-1:0]      wb_au_reg;
    logic [au_pkg::data_width-1:0]         wb_au_data;
    logic                                  wb_au_flags_en;
    logic [au_pkg::flag_width-1:0]         wb_au_flags;

    typedef struct packed {
        logic        store;
        logic        flag;
        logic [2:0]  dst;
        logic [31:0] data;
        logic [3:0]  flags;
    } wb_t;

    // Model register file and predicted writebacks in issue order
    logic [31:0] model_regs [8];
    wb_t         exp_q [$];
    wb_t         pending;

    au_top dut
    (
        .clk            (clk),
        .rst            (rst),
        .au_op_en       (au_op_en),
        .au_op          (au_op),
        .rf_imm_en      (rf_imm_en),
        .rf_imm_reg     (rf_imm_reg),
        .rf_imm         (rf_imm),
        .wb_au_en       (wb_au_en),
        .wb_au_reg      (wb_au_reg),
        .wb_au_data     (wb_au_data),
        .wb_au_flags_en (wb_au_flags_en),
        .wb_au_flags    (wb_au_flags)
    );

    bind au_top au_checker chk
    (
        .clk            (clk),
        .rst            (rst),
        .au_op_en       (au_op_en),
        .au_op          (au_op),
        .rf_imm_en      (rf_imm_en),
        .wb_au_en       (wb_au_en),
        .wb_au_flags_en (wb_au_flags_en)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #20 clk = ~clk;
        end
    end

    task automatic stop_with_failure();
        $display("Result: FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected)
        else
        begin
            $display("mismatch at %0d ns: %s is 0x%0h, expected 0x%0h",
                     $time, name, got, expected);
            stop_with_failure();
        end
    endtask

    task automatic drive_inputs(input logic op_en, input logic [14:0] op, input logic imm_en,
                                input logic [2:0] imm_reg, input logic [31:0] imm);
        @(posedge clk);
        #2;
        au_op_en   = op_en;
        au_op      = op;
        rf_imm_en  = imm_en;
        rf_imm_reg = imm_reg;
        rf_imm     = imm;
    endtask

    // Both strobes low with random payloads
    task automatic drive_idle();
        drive_inputs(1'b0, 15'($urandom), 1'b0, 3'($urandom), $urandom);
    endtask

    function automatic logic [14:0] alu3_op(input logic [3:0] func, input logic [2:0] dst,
                                            input logic [2:0] src_b, input logic [2:0] src_a);
        return {2'b00, func, dst, src_b, src_a};
    endfunction

    function automatic logic [14:0] unary_op(input logic [4:0] func, input logic [2:0] src_b,
                                             input logic [2:0] src_a);
        return {4'b0100, func, src_b, src_a};
    endfunction

    function automatic logic [14:0] random_op();
        logic [14:0] op;
        op = 15'($urandom);
        case ($urandom_range(9))
            0, 1, 2, 3:
            begin
                // Code 5 is unused and gives zero
                op[14:13] = 2'b00;
                op[12:9]  = 4'($urandom_range(5));
            end
            4, 5:
            begin
                op[14:11] = 4'b0100;
                if ($urandom_range(3) == 0)
                begin
                    op[10:7] = 4'hF;
                end
                else if ($urandom_range(5) != 0)
                begin
                    op[10:8] = 3'b000;
                end
            end
            6, 7, 8:
            begin
                op[14:11] = 4'b0101;
            end
            default:
            begin
                if ($urandom_range(1) == 0)
                begin
                    op[14] = 1'b1;
                end
                else
                begin
                    op[14:12] = 3'b011;
                end
            end
        endcase
        return op;
    endfunction

    // Expected writeback for the inputs sampled at one edge
    function automatic wb_t predict(input logic op_en, input logic [14:0] op,
                                    input logic imm_en, input logic [2:0] imm_reg,
                                    input logic [31:0] imm);
        wb_t                e;
        au_pkg::op_kind_t   kind;
        logic               known;
        logic [31:0]        a;
        logic [31:0]        b;
        logic [31:0]        r;
        logic [4:0]         sh;
        logic               c;
        logic               v;
        logic signed [63:0] wide;
        e = '0;
        if (imm_en)
        begin
            e.store = 1'b1;
            e.dst   = imm_reg;
            e.data  = imm;
            return e;
        end
        if (!op_en)
        begin
            return e;
        end
        a     = model_regs[op[2:0]];
        b     = model_regs[op[5:3]];
        sh    = op[7:3];
        r     = '0;
        c     = 1'b0;
        v     = 1'b0;
        known = 1'b1;
        kind  = au_pkg::k_zero;
        e.dst = op[2:0];
        if (op[14:13] == 2'b00)
        begin
            e.dst = op[8:6];
            case (op[12:9])
                4'd0:    kind = au_pkg::k_or;
                4'd1:    kind = au_pkg::k_and;
                4'd2:    kind = au_pkg::k_xor;
                4'd3:    kind = au_pkg::k_add;
                4'd4:    kind = au_pkg::k_sub;
                default: kind = au_pkg::k_zero;
            endcase
        end
        else if (op[14:11] == 4'b0100)
        begin
            case (op[10:6])
                5'h00:   kind = au_pkg::k_not;
                5'h01:   kind = au_pkg::k_neg;
                5'h02:   kind = au_pkg::k_sext8;
                5'h03:   kind = au_pkg::k_sext16;
                5'h1E:   kind = au_pkg::k_test;
                5'h1F:   kind = au_pkg::k_cmp;
                default: kind = au_pkg::k_zero;
            endcase
        end
        else if (op[14:11] == 4'b0101)
        begin
            case (op[10:8])
                3'd0:    kind = au_pkg::k_bclr;
                3'd1:    kind = au_pkg::k_bset;
                3'd4:    kind = au_pkg::k_shl;
                3'd5:    kind = au_pkg::k_shr;
                3'd6:    kind = au_pkg::k_asr;
                default: kind = au_pkg::k_zero;
            endcase
        end
        else
        begin
            known = 1'b0;
        end
        if (!known)
        begin
            return e;
        end
        case (kind)
            au_pkg::k_or:     r = a | b;
            au_pkg::k_and:    r = a & b;
            au_pkg::k_xor:    r = a ^ b;
            au_pkg::k_add:
            begin
                {c, r} = {1'b0, a} + {1'b0, b};
                wide   = $signed(a) + $signed(b);
                v      = wide[32] != wide[31];
            end
            au_pkg::k_sub, au_pkg::k_cmp:
            begin
                r    = a - b;
                c    = a < b;
                wide = $signed(a) - $signed(b);
                v    = wide[32] != wide[31];
            end
            au_pkg::k_not:    r = ~b;
            au_pkg::k_neg:
            begin
                r = 32'd0 - b;
                c = b != 32'd0;
                v = b == 32'h8000_0000;
            end
            au_pkg::k_sext8:  r = {{24{b[7]}}, b[7:0]};
            au_pkg::k_sext16: r = {{16{b[15]}}, b[15:0]};
            au_pkg::k_test:   r = a & b;
            au_pkg::k_bclr:   r = a & ~(32'd1 << sh);
            au_pkg::k_bset:   r = a | (32'd1 << sh);
            au_pkg::k_shl:    r = a << sh;
            au_pkg::k_shr:    r = a >> sh;
            au_pkg::k_asr:    r = $signed(a) >>> sh;
            default:          r = '0;
        endcase
        e.store = (kind != au_pkg::k_test) && (kind != au_pkg::k_cmp);
        e.flag  = 1'b1;
        e.data  = r;
        e.flags = {v, c, r[31], r == 32'd0};
        return e;
    endfunction

    function automatic logic pipeline_busy();
        logic busy;
        busy = pending.store;
        foreach (exp_q[i])
        begin
            busy = busy || exp_q[i].store || exp_q[i].flag;
        end
        return busy;
    endfunction

    // Model step between the clock edge and the next input change
    always @(posedge clk)
    begin
        wb_t exp;
        #1;
        if (rst)
        begin
            exp_q.delete();
            repeat (3) exp_q.push_back('0);
            pending = '0;
            for (int i = 0; i < 8; i++)
            begin
                model_regs[i] = '0;
            end
        end
        else
        begin
            exp_q.push_back(predict(au_op_en, au_op, rf_imm_en, rf_imm_reg, rf_imm));
            // Register file takes the write one edge after it shows
            if (pending.store)
            begin
                model_regs[pending.dst] = pending.data;
            end
            exp = exp_q.pop_front();
            check_value("wb_au_en", wb_au_en, exp.store);
            check_value("wb_au_flags_en", wb_au_flags_en, exp.flag);
            if (exp.store)
            begin
                check_value("wb_au_reg", wb_au_reg, exp.dst);
                check_value("wb_au_data", wb_au_data, exp.data);
            end
            if (exp.flag)
            begin
                check_value("wb_au_flags", wb_au_flags, exp.flags);
            end
            pending = exp;
            if (dut.chk.fail_count != 0)
            begin
                $display("a port assertion on the DUT failed");
                stop_with_failure();
            end
        end
    end

    initial
    begin
        logic [31:0] start_val;
        int unsigned sel;
        au_op_en   = 1'b0;
        au_op      = '0;
        rf_imm_en  = 1'b0;
        rf_imm_reg = '0;
        rf_imm     = '0;
        rst        = 1'b1;
        void'($urandom(32'ha3b2c763));
        repeat (3) @(posedge clk);
        #2 rst = 1'b0;

        for (int i = 0; i < 8; i++)
        begin
            case (i)
                0:       start_val = 32'h8000_0000;
                1:       start_val = 32'h7fff_ffff;
                2:       start_val = 32'hffff_ffff;
                3:       start_val = 32'h0000_0000;
                default: start_val = $urandom;
            endcase
            drive_inputs(1'b0, 15'd0, 1'b1, 3'(i), start_val);
        end
        repeat (4) drive_idle();

        // r1 doubled back to back where every issue reads the old value
        repeat (5) drive_inputs(1'b1, alu3_op(4'd3, 3'd1, 3'd1, 3'd1), 1'b0, 3'd0, 32'd0);
        drive_inputs(1'b1, unary_op(5'h01, 3'd0, 3'd4), 1'b0, 3'd0, 32'd0);
        drive_inputs(1'b1, alu3_op(4'd4, 3'd5, 3'd2, 3'd3), 1'b0, 3'd0, 32'd0);
        drive_inputs(1'b1, unary_op(5'h1F, 3'd1, 3'd0), 1'b0, 3'd0, 32'd0);
        drive_inputs(1'b1, unary_op(5'h1E, 3'd2, 3'd2), 1'b0, 3'd0, 32'd0);
        drive_inputs(1'b1, alu3_op(4'd3, 3'd7, 3'd2, 3'd2), 1'b1, 3'd7, 32'h1234_5678);
        drive_inputs(1'b1, 15'h7fff, 1'b0, 3'd0, 32'd0);
        drive_idle();

        for (int n = 0; n < 300; n++)
        begin
            sel = $urandom_range(19);
            if (sel == 0)
            begin
                drive_inputs(1'b1, random_op(), 1'b1, 3'($urandom), $urandom);
            end
            else if (sel < 3)
            begin
                drive_inputs(1'b0, 15'($urandom), 1'b1, 3'($urandom), $urandom);
            end
            else
            begin
                drive_inputs(1'b1, random_op(), 1'b0, 3'($urandom), $urandom);
            end
            if ($urandom_range(1) == 0)
            begin
                repeat ($urandom_range(3)) drive_idle();
            end
        end

        drive_idle();
        for (int t = 0; pipeline_busy(); t++)
        begin
            if (t == 8)
            begin
                $display("pipeline still busy long after the last issue");
                stop_with_failure();
            end
            drive_idle();
        end
        drive_idle();

        if (dut.chk.fail_count != 0)
        begin
            $display("Result: FAILED");
            $fatal(1, "port assertions on the DUT failed");
        end
        else
        begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: verilog.f
common/au_pkg.sv
common/au_operand_if.sv
common/au_result_if.sv
hdl/au_reg_file.sv
au/au_operand_fetch.sv
au/au_execute.sv
au/au_writeback.sv
hdl/au_top.sv
verif/au_checker.sv
verif/au_tb.sv
